/* common/kcpu_pkg.sv */
`default_nettype none

package kcpu_pkg;

    // Datapath widths
    localparam int WORD_W    = 16;                     // Operand and result width
    localparam int BYTE_W    = 8;                      // Narrow form width
    localparam int OP_W      = 6;                      // ALU operation code width
    localparam int DIV_STEPS = 8;                      // One quotient bit per enabled cycle
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);  // Divider step counter width

    // Condition-code bit positions
    localparam int CC_C = 0;  // Carry or borrow
    localparam int CC_V = 1;  // Signed overflow
    localparam int CC_Z = 2;  // Zero
    localparam int CC_N = 3;  // Negative
    localparam int CC_I = 4;  // IRQ mask
    localparam int CC_H = 5;  // Half carry
    localparam int CC_F = 6;  // FIRQ mask
    localparam int CC_E = 7;  // Entire state saved

    typedef logic [BYTE_W-1:0] kcpu_cc_t;

    // Compact ALU operation codes with the width carried in the request
    typedef enum logic [OP_W-1:0] {
        LD    = 6'd0,  // Load or test opnd1
        ST,            // Store or transfer opnd0
        ADD,
        ADC,           // Add with carry in
        SUB,
        SBC,           // Subtract with borrow in
        CMP,           // Subtract, flags only matter
        AND,
        OR,
        EOR,
        ANDCC,         // cc_in masked by opnd1 low byte
        ORCC,
        CLR,
        COM,
        NEG,
        INC,
        DEC,
        LSR,
        ASR,
        ASL,
        ROL,           // Through carry
        ROR,           // Through carry
        DAA,           // BCD adjust of opnd0 low byte
        SEX,           // Sign extend opnd0 low byte
        MUL,           // 8x8 unsigned
        LMUL,          // 16x16 unsigned, upper word on rslt_hi
        ABS,
        DIVU,          // 16/8 unsigned, multi-cycle
        DIVS           // 16/8 signed, multi-cycle
    } kcpu_alu_op_e;

    // One ALU request as issued by the core
    typedef struct packed {
        kcpu_alu_op_e      op;
        logic              wide;   // Select 16-bit form
        logic [WORD_W-1:0] opnd0;  // Accumulator side
        logic [WORD_W-1:0] opnd1;  // Memory or immediate side
    } kcpu_alu_req_t;

endpackage

`default_nettype wire

/* alu/kcpu_div.sv */
`timescale 1ns/100ps
`default_nettype none

module kcpu_div (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        start,
    input  logic                        sign,
    input  logic [kcpu_pkg::WORD_W-1:0] dividend,
    input  logic [kcpu_pkg::BYTE_W-1:0] divisor,
    output logic [kcpu_pkg::BYTE_W-1:0] quot,
    output logic [kcpu_pkg::BYTE_W-1:0] rem,
    output logic                        busy,
    output logic                        v
);
    import kcpu_pkg::*;

    logic [BYTE_W-1:0]    acc;     // Partial remainder
    logic [BYTE_W-1:0]    quo;     // Dividend low byte, shifts into quotient
    logic [BYTE_W-1:0]    dvs;     // Divisor magnitude
    logic [DIV_CNT_W-1:0] cnt;
    logic                 sgn_q;
    logic                 neg_q;   // Quotient gets negated
    logic                 neg_r;   // Remainder follows dividend sign
    logic                 ovf;     // Zero divisor or unsigned quotient too big
    logic                 q_big;
    logic [WORD_W-1:0]    dd_abs;
    logic [BYTE_W-1:0]    dv_abs;
    logic [BYTE_W+1:0]    trial;

    assign dd_abs = (sign && dividend[WORD_W-1]) ? -dividend : dividend;
    assign dv_abs = (sign && divisor[BYTE_W-1]) ? -divisor : divisor;
    assign trial  = {1'b0, acc, quo[BYTE_W-1]} - {2'b00, dvs};  // MSB set means no fit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (cen) begin
            if (start && !busy) begin
                busy <= 1'b1;
                cnt  <= DIV_CNT_W'(DIV_STEPS);
            end else if (busy) begin
                cnt  <= cnt - 1'b1;
                busy <= cnt != DIV_CNT_W'(1);  // Last step drops busy
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (start && !busy) begin
                acc   <= dd_abs[WORD_W-1:BYTE_W];
                quo   <= dd_abs[BYTE_W-1:0];
                dvs   <= dv_abs;
                sgn_q <= sign;
                neg_q <= sign && (dividend[WORD_W-1] ^ divisor[BYTE_W-1]);
                neg_r <= sign && dividend[WORD_W-1];
                ovf   <= dv_abs == '0 || dd_abs[WORD_W-1:BYTE_W] >= dv_abs;
            end else if (busy) begin
                acc <= trial[BYTE_W+1] ? {acc[BYTE_W-2:0], quo[BYTE_W-1]} : trial[BYTE_W-1:0];
                quo <= {quo[BYTE_W-2:0], ~trial[BYTE_W+1]};
            end
        end
    end

    // Signed result must fit -128..127
    assign q_big = sgn_q && (neg_q ? (quo[BYTE_W-1] && |quo[BYTE_W-2:0]) : quo[BYTE_W-1]);

    assign quot = neg_q ? -quo : quo;
    assign rem  = neg_r ? -acc : acc;
    assign v    = ovf || q_big;

    // Busy lasts exactly DIV_STEPS enabled cycles after an accepted start
    assert property (@(posedge clk) disable iff (!rst_n)
        cen && start && !busy |=> (busy throughout cen [->DIV_STEPS]) ##1 !busy)
        else $error("divider busy length is not %0d enabled cycles", DIV_STEPS);

endmodule

`default_nettype wire

/* alu/kcpu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module kcpu_alu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        start,
    input  kcpu_pkg::kcpu_alu_req_t     req,
    input  kcpu_pkg::kcpu_cc_t          cc_in,
    output kcpu_pkg::kcpu_cc_t          cc_out,
    output logic                        busy,
    output logic [kcpu_pkg::WORD_W-1:0] rslt,
    output logic [kcpu_pkg::WORD_W-1:0] rslt_hi
);
    import kcpu_pkg::*;

    logic              is_div;
    logic              is_ccop;
    logic              wide16;   // Result sign at bit 15
    logic              keep_hi;  // Upper byte of rslt is meaningful
    logic [3:0]        msb;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic              cin;
    logic [WORD_W:0]   sum;
    logic [BYTE_W-1:0] daa_adj;
    logic [BYTE_W:0]   daa_sum;
    logic [BYTE_W-1:0] div_quot;
    logic [BYTE_W-1:0] div_rem;
    logic              div_v;

    assign is_div  = req.op inside {DIVU, DIVS};
    assign is_ccop = req.op inside {ANDCC, ORCC};
    assign wide16  = (req.wide && !is_div) || req.op inside {SEX, MUL, LMUL};
    assign keep_hi = wide16 || is_div;
    assign msb     = wide16 ? 4'(WORD_W - 1) : 4'(BYTE_W - 1);
    assign a       = wide16 ? req.opnd0 : {{BYTE_W{1'b0}}, req.opnd0[BYTE_W-1:0]};
    assign b       = wide16 ? req.opnd1 : {{BYTE_W{1'b0}}, req.opnd1[BYTE_W-1:0]};
    assign cin     = cc_in[CC_C];

    kcpu_div kcpu_div_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .start    (start),
        .sign     (req.op == DIVS),
        .dividend (req.opnd0),
        .divisor  (req.opnd1[BYTE_W-1:0]),
        .quot     (div_quot),
        .rem      (div_rem),
        .busy     (busy),
        .v        (div_v)
    );

    always_comb begin
        cc_out  = cc_in;  // Unnamed flags pass through
        rslt    = '0;
        rslt_hi = '0;
        sum     = '0;
        daa_adj = '0;
        daa_sum = '0;
        case (req.op)
            LD: begin
                rslt         = b;
                cc_out[CC_V] = 1'b0;
            end
            ST: begin
                rslt         = a;
                cc_out[CC_V] = 1'b0;
            end
            ADD, ADC: begin
                sum          = {1'b0, a} + {1'b0, b} + {{WORD_W{1'b0}}, req.op == ADC && cin};
                rslt         = sum[WORD_W-1:0];
                cc_out[CC_C] = wide16 ? sum[WORD_W] : sum[BYTE_W];
                cc_out[CC_V] = (a[msb] & b[msb] & ~rslt[msb]) | (~a[msb] & ~b[msb] & rslt[msb]);
                if (!wide16) begin
                    cc_out[CC_H] = a[4] ^ b[4] ^ rslt[4];  // Carry into bit 4
                end
            end
            SUB, SBC, CMP: begin
                sum          = {1'b0, a} - {1'b0, b} - {{WORD_W{1'b0}}, req.op == SBC && cin};
                rslt         = sum[WORD_W-1:0];
                cc_out[CC_C] = wide16 ? sum[WORD_W] : sum[BYTE_W];  // Borrow
                cc_out[CC_V] = (a[msb] & ~b[msb] & ~rslt[msb]) | (~a[msb] & b[msb] & rslt[msb]);
            end
            AND, OR, EOR: begin
                rslt         = req.op == AND ? a & b : req.op == OR ? a | b : a ^ b;
                cc_out[CC_V] = 1'b0;
            end
            ANDCC: cc_out = cc_in & req.opnd1[BYTE_W-1:0];
            ORCC:  cc_out = cc_in | req.opnd1[BYTE_W-1:0];
            CLR: begin
                cc_out[CC_C] = 1'b0;
                cc_out[CC_V] = 1'b0;
            end
            COM: begin
                rslt         = ~a;
                cc_out[CC_C] = 1'b1;
                cc_out[CC_V] = 1'b0;
            end
            NEG: begin
                sum          = '0 - {1'b0, a};
                rslt         = sum[WORD_W-1:0];
                cc_out[CC_C] = wide16 ? sum[WORD_W] : sum[BYTE_W];  // Set unless operand is zero
                cc_out[CC_V] = a[msb] & rslt[msb];                // Only the most negative value
            end
            INC: begin
                rslt         = a + 1'b1;
                cc_out[CC_V] = ~a[msb] & rslt[msb];
            end
            DEC: begin
                rslt         = a - 1'b1;
                cc_out[CC_V] = a[msb] & ~rslt[msb];
            end
            LSR: begin
                rslt         = a >> 1;
                cc_out[CC_C] = a[0];
            end
            ASR: begin
                rslt         = a >> 1;
                rslt[msb]    = a[msb];  // Keep sign
                cc_out[CC_C] = a[0];
            end
            ASL: begin
                rslt         = a << 1;
                cc_out[CC_C] = a[msb];
                cc_out[CC_V] = a[msb] ^ rslt[msb];
            end
            ROL: begin
                rslt         = {a[WORD_W-2:0], cin};
                cc_out[CC_C] = a[msb];
                cc_out[CC_V] = a[msb] ^ rslt[msb];
            end
            ROR: begin
                rslt         = a >> 1;
                rslt[msb]    = cin;
                cc_out[CC_C] = a[0];
            end
            DAA: begin
                // Upper digit correction also covers a lower-digit carry into 9x
                daa_adj[7:4] = (cin || a[7:4] > 4'h9 || (a[7:4] > 4'h8 && a[3:0] > 4'h9)) ?
                               4'h6 : 4'h0;
                daa_adj[3:0] = (cc_in[CC_H] || a[3:0] > 4'h9) ? 4'h6 : 4'h0;
                daa_sum      = {1'b0, a[BYTE_W-1:0]} + {1'b0, daa_adj};
                rslt         = {{BYTE_W{1'b0}}, daa_sum[BYTE_W-1:0]};
                cc_out[CC_C] = cin | daa_sum[BYTE_W];
            end
            SEX: begin
                rslt         = {{BYTE_W{req.opnd0[BYTE_W-1]}}, req.opnd0[BYTE_W-1:0]};
                cc_out[CC_V] = 1'b0;
            end
            MUL: begin
                rslt         = req.opnd0[BYTE_W-1:0] * req.opnd1[BYTE_W-1:0];
                cc_out[CC_C] = rslt[7];  // Rounding bit for fixed point use
            end
            LMUL: begin
                {rslt_hi, rslt} = req.opnd0 * req.opnd1;
                cc_out[CC_C]    = rslt_hi[WORD_W-1];
            end
            ABS: begin
                rslt         = a[msb] ? -a : a;
                cc_out[CC_C] = 1'b0;
                cc_out[CC_V] = 1'b0;
            end
            DIVU, DIVS: begin
                rslt         = div_v ? req.opnd0 : {div_rem, div_quot};
                cc_out[CC_V] = div_v;
            end
            default: rslt = req.opnd0;
        endcase

        if (!keep_hi) begin
            rslt[WORD_W-1:BYTE_W] = '0;  // Narrow forms return a clean upper byte
        end
        if (is_div) begin
            cc_out[CC_Z] = div_quot == '0;
        end else if (!is_ccop) begin
            cc_out[CC_Z] = rslt == '0;
        end
        if (!is_ccop && !(req.op inside {MUL, LMUL})) begin
            cc_out[CC_N] = rslt[msb];
        end
    end

    // A new division must wait for the running one
    assert property (@(posedge clk) disable iff (!rst_n) cen && start |-> !busy)
        else $error("divider started while busy");

endmodule

`default_nettype wire

/* hdl/kcpu_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module kcpu_exec (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        go,
    input  kcpu_pkg::kcpu_alu_req_t     req,
    input  logic                        cc_wr,
    input  kcpu_pkg::kcpu_cc_t          cc_wdata,
    output logic                        busy,
    output logic                        done,
    output logic [kcpu_pkg::WORD_W-1:0] rslt,
    output logic [kcpu_pkg::WORD_W-1:0] rslt_hi,
    output kcpu_pkg::kcpu_cc_t          cc
);
    import kcpu_pkg::*;

    kcpu_alu_req_t     req_q;     // Held for the whole division
    logic              req_vld;   // req_q was captured on the last enabled edge
    logic              div_pend;  // Division running or waiting to be loaded
    logic              is_div;
    logic              start;
    logic              accept;
    logic              load;
    logic [WORD_W-1:0] alu_rslt;
    logic [WORD_W-1:0] alu_rslt_hi;
    kcpu_cc_t          alu_cc;

    assign is_div = req_q.op inside {DIVU, DIVS};
    assign start  = req_vld && is_div;
    assign accept = go && !busy && !div_pend && !start;
    assign load   = (req_vld && !is_div) || (div_pend && !busy);  // Edge after busy falls

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_vld  <= 1'b0;
            div_pend <= 1'b0;
        end else if (cen) begin
            req_vld <= accept;
            if (start) begin
                div_pend <= 1'b1;
            end else if (load) begin
                div_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && accept) begin
            req_q <= req;
        end
    end

    kcpu_alu kcpu_alu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .start   (start),
        .req     (req_q),
        .cc_in   (cc),
        .cc_out  (alu_cc),
        .busy    (busy),
        .rslt    (alu_rslt),
        .rslt_hi (alu_rslt_hi)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rslt    <= '0;
            rslt_hi <= '0;
            cc      <= '0;
        end else if (cen) begin
            if (load) begin
                rslt    <= alu_rslt;
                rslt_hi <= alu_rslt_hi;
                cc      <= alu_cc;
            end else if (cc_wr) begin
                cc <= cc_wdata;  // Loses to a result update
            end
        end
    end

    // Single clock pulse even when cen is low on the following cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= cen && load;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else $error("done raised while the divider is busy");
    assert property (@(posedge clk) disable iff (!rst_n) cen && go |-> !busy)
        else $error("request issued while the divider is busy");

endmodule

`default_nettype wire

/* dv/kcpu_exec_vectors.svh */
`ifndef KCPU_EXEC_VECTORS_SVH
`define KCPU_EXEC_VECTORS_SVH

// Columns are cc preload, op, wide, opnd0, opnd1, rslt, rslt_hi and cc
// cc bits are E F H I N Z V C from bit 7 down
task automatic fill_table();
    add_vec(8'h00, ADD,   1'b0, 16'h0048, 16'h0038, 16'h0080, 16'h0000, 8'h2A);
    add_vec(8'h01, ADC,   1'b0, 16'h00FF, 16'h0000, 16'h0000, 16'h0000, 8'h25);
    add_vec(8'h20, ADD,   1'b1, 16'h7FFF, 16'h0001, 16'h8000, 16'h0000, 8'h2A);
    add_vec(8'h00, SUB,   1'b0, 16'h0010, 16'h0020, 16'h00F0, 16'h0000, 8'h09);
    add_vec(8'h11, SBC,   1'b1, 16'h1000, 16'h0001, 16'h0FFE, 16'h0000, 8'h10);
    add_vec(8'h00, CMP,   1'b0, 16'h0042, 16'h0042, 16'h0000, 16'h0000, 8'h04);
    add_vec(8'h00, CMP,   1'b1, 16'h8000, 16'h0001, 16'h7FFF, 16'h0000, 8'h02);
    add_vec(8'h03, AND,   1'b0, 16'h00F0, 16'h003C, 16'h0030, 16'h0000, 8'h01);
    add_vec(8'h00, OR,    1'b1, 16'h8000, 16'h0001, 16'h8001, 16'h0000, 8'h08);
    add_vec(8'h08, EOR,   1'b0, 16'h0055, 16'h0055, 16'h0000, 16'h0000, 8'h04);
    add_vec(8'hFF, ANDCC, 1'b0, 16'h0000, 16'h00AF, 16'h0000, 16'h0000, 8'hAF);
    add_vec(8'h00, ORCC,  1'b0, 16'h0000, 16'h0050, 16'h0000, 16'h0000, 8'h50);
    add_vec(8'h0B, CLR,   1'b0, 16'h0012, 16'h0000, 16'h0000, 16'h0000, 8'h04);
    add_vec(8'h00, COM,   1'b0, 16'h000F, 16'h0000, 16'h00F0, 16'h0000, 8'h09);
    add_vec(8'h00, NEG,   1'b0, 16'h0080, 16'h0000, 16'h0080, 16'h0000, 8'h0B);
    add_vec(8'h01, INC,   1'b0, 16'h007F, 16'h0000, 16'h0080, 16'h0000, 8'h0B);
    add_vec(8'h00, DEC,   1'b1, 16'h0001, 16'h0000, 16'h0000, 16'h0000, 8'h04);
    add_vec(8'h00, LSR,   1'b0, 16'h0081, 16'h0000, 16'h0040, 16'h0000, 8'h01);
    add_vec(8'h00, ASR,   1'b0, 16'h0081, 16'h0000, 16'h00C0, 16'h0000, 8'h09);
    add_vec(8'h00, ASL,   1'b0, 16'h00C0, 16'h0000, 16'h0080, 16'h0000, 8'h09);
    add_vec(8'h01, ROL,   1'b0, 16'h0040, 16'h0000, 16'h0081, 16'h0000, 8'h0A);
    add_vec(8'h01, ROR,   1'b1, 16'h0002, 16'h0000, 16'h8001, 16'h0000, 8'h08);
    add_vec(8'h00, DAA,   1'b0, 16'h003C, 16'h0000, 16'h0042, 16'h0000, 8'h00);
    add_vec(8'h00, DAA,   1'b0, 16'h009A, 16'h0000, 16'h0000, 16'h0000, 8'h05);
    add_vec(8'h02, SEX,   1'b0, 16'h0085, 16'h0000, 16'hFF85, 16'h0000, 8'h08);
    add_vec(8'h03, ABS,   1'b0, 16'h00FE, 16'h0000, 16'h0002, 16'h0000, 8'h00);
    add_vec(8'h01, LD,    1'b1, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'h05);
    add_vec(8'h00, LD,    1'b0, 16'h0000, 16'h1280, 16'h0080, 16'h0000, 8'h08);
    add_vec(8'h08, MUL,   1'b0, 16'h0010, 16'h0008, 16'h0080, 16'h0000, 8'h09);
    add_vec(8'h00, MUL,   1'b0, 16'h00FF, 16'h00FF, 16'hFE01, 16'h0000, 8'h00);
    add_vec(8'h00, LMUL,  1'b1, 16'hFFFF, 16'hFFFF, 16'h0001, 16'hFFFE, 8'h01);
    add_vec(8'h00, DIVU,  1'b0, 16'h1234, 16'h0056, 16'h1036, 16'h0000, 8'h00);
    add_vec(8'h00, DIVS,  1'b0, 16'hFF9C, 16'h0007, 16'hFEF2, 16'h0000, 8'h08);
    add_vec(8'h00, DIVS,  1'b0, 16'h03E8, 16'h00F7, 16'h0191, 16'h0000, 8'h08);
    add_vec(8'h00, DIVU,  1'b0, 16'h1234, 16'h0000, 16'h1234, 16'h0000, 8'h02);
    add_vec(8'h00, DIVU,  1'b0, 16'hFF00, 16'h0001, 16'hFF00, 16'h0000, 8'h02);
    add_vec(8'h00, DIVS,  1'b0, 16'h0080, 16'h0001, 16'h0080, 16'h0000, 8'h0A);
endtask

`endif

/* dv/kcpu_exec_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module kcpu_exec_tb;
    import kcpu_pkg::*;

    typedef struct packed {
        kcpu_cc_t          pre;   // cc loaded before the request
        kcpu_alu_op_e      op;
        logic              wide;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] r;
        logic [WORD_W-1:0] hi;
        kcpu_cc_t          cc;
    } vec_t;

    localparam int N_RAND = 12;
    localparam int N_B2B  = 4;

    logic              clk;
    logic              rst_n;
    logic              cen;
    logic              go;
    kcpu_alu_req_t     req;
    logic              cc_wr;
    kcpu_cc_t          cc_wdata;
    logic              busy;
    logic              done;
    logic [WORD_W-1:0] rslt;
    logic [WORD_W-1:0] rslt_hi;
    kcpu_cc_t          cc;
    logic              toggle_cen;   // Division tests run with cen every other cycle
    logic              table_ready;
    vec_t              vecs[$];
    int                n_pass;
    int                n_fail;
    int                test_errs;
    int                cur_test;
    integer            seed;

    `include "kcpu_exec_vectors.svh"

    kcpu_exec kcpu_exec_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .go       (go),
        .req      (req),
        .cc_wr    (cc_wr),
        .cc_wdata (cc_wdata),
        .busy     (busy),
        .done     (done),
        .rslt     (rslt),
        .rslt_hi  (rslt_hi),
        .cc       (cc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cen <= toggle_cen ? ~cen : 1'b1;
    end

    task automatic add_vec(input kcpu_cc_t pre, input kcpu_alu_op_e op, input logic wide,
                           input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
                           input logic [WORD_W-1:0] r, input logic [WORD_W-1:0] hi,
                           input kcpu_cc_t exp_cc);
        vec_t v;
        v = '{pre, op, wide, a, b, r, hi, exp_cc};
        vecs.push_back(v);
    endtask

    task automatic check_value(input string sig, input logic [WORD_W-1:0] exp_v,
                               input logic [WORD_W-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("error test %0d %s expected %h got %h", cur_test, sig, exp_v, act_v);
            test_errs++;
        end
    endtask

    // Returns on the first edge where the DUT saw cen high
    task automatic wait_taken();
        @(posedge clk);
        while (!cen) @(posedge clk);
    endtask

    task automatic run_vector(input vec_t v, output int busy_cnt);
        kcpu_alu_req_t rq;
        rq.op    = v.op;
        rq.wide  = v.wide;
        rq.opnd0 = v.a;
        rq.opnd1 = v.b;
        @(posedge clk);
        cc_wr    <= 1'b1;
        cc_wdata <= v.pre;
        wait_taken();
        cc_wr <= 1'b0;
        go    <= 1'b1;
        req   <= rq;
        wait_taken();
        go       <= 1'b0;
        busy_cnt = 0;
        while (!done) begin
            @(posedge clk);
            if (busy && cen) busy_cnt++;
        end
        check_value("rslt", v.r, rslt);
        check_value("rslt_hi", v.hi, rslt_hi);
        check_value("cc", {8'h00, v.cc}, {8'h00, cc});
    endtask

    // Expected values for 16-bit ADD, SUB and LMUL from the flag rules
    function automatic vec_t ref_arith(kcpu_alu_op_e op, logic [WORD_W-1:0] a,
                                       logic [WORD_W-1:0] b);
        vec_t        v;
        logic [16:0] s;
        logic [31:0] p;
        v      = '0;
        v.op   = op;
        v.wide = 1'b1;
        v.a    = a;
        v.b    = b;
        if (op == ADD) begin
            s          = {1'b0, a} + {1'b0, b};
            v.r        = s[15:0];
            v.cc[CC_C] = s[16];
            v.cc[CC_V] = (a[15] == b[15]) && (v.r[15] != a[15]);
        end else if (op == SUB) begin
            s          = {1'b0, a} - {1'b0, b};
            v.r        = s[15:0];
            v.cc[CC_C] = a < b;  // Borrow
            v.cc[CC_V] = (a[15] != b[15]) && (v.r[15] != a[15]);
        end else begin
            p          = a * b;
            v.r        = p[15:0];
            v.hi       = p[31:16];
            v.cc[CC_C] = p[31];
        end
        v.cc[CC_Z] = v.r == '0;
        if (op != LMUL) v.cc[CC_N] = v.r[15];  // LMUL leaves N alone
        return v;
    endfunction

    task automatic close_test(input string what);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %0d %s ok", cur_test, what);
        end else begin
            n_fail++;
            $display("test %0d %s failed with %0d errors", cur_test, what, test_errs);
        end
        cur_test++;
        test_errs = 0;
    endtask

    initial begin
        wait (table_ready);
        repeat (20 * (vecs.size() + N_RAND + N_B2B + 1)) @(posedge clk);
        $display("timeout, the tests did not finish within the cycle budget");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        kcpu_alu_req_t     b2b_req[N_B2B];
        logic [WORD_W-1:0] b2b_r[N_B2B];
        vec_t              v;
        int                busy_cnt;
        seed        = 32'h31c9_426b;
        rst_n       = 1'b0;
        cen         = 1'b1;
        go          = 1'b0;
        req         = '0;
        cc_wr       = 1'b0;
        cc_wdata    = '0;
        toggle_cen  = 1'b0;
        n_pass      = 0;
        n_fail      = 0;
        test_errs   = 0;
        cur_test    = 0;
        table_ready = 1'b0;
        fill_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("rslt", '0, rslt);
        check_value("rslt_hi", '0, rslt_hi);
        check_value("cc", '0, {8'h00, cc});
        check_value("done", '0, {15'h0, done});
        check_value("busy", '0, {15'h0, busy});
        close_test("reset");

        foreach (vecs[i]) begin
            toggle_cen <= vecs[i].op inside {DIVU, DIVS};
            run_vector(vecs[i], busy_cnt);
            if (toggle_cen && busy_cnt != 8) begin
                $display("error test %0d busy_cycles expected %h got %h", cur_test, 8, busy_cnt);
                test_errs++;
            end
            close_test("table");
        end
        toggle_cen <= 1'b0;

        for (int i = 0; i < N_RAND; i++) begin
            v = ref_arith(i % 3 == 0 ? ADD : i % 3 == 1 ? SUB : LMUL,
                          16'($random(seed)), 16'($random(seed)));
            run_vector(v, busy_cnt);
            close_test("random");
        end

        b2b_req[0] = '{ADD, 1'b0, 16'h0012, 16'h0034};
        b2b_req[1] = '{EOR, 1'b1, 16'hF0F0, 16'h0FF0};
        b2b_req[2] = '{INC, 1'b0, 16'h00FF, 16'h0000};
        b2b_req[3] = '{LD, 1'b1, 16'h0000, 16'hBEEF};
        b2b_r      = '{16'h0046, 16'hFF00, 16'h0000, 16'hBEEF};
        // A request driven after edge k is taken at k+1 and seen settled at k+3
        for (int i = 0; i < N_B2B + 3; i++) begin
            @(posedge clk);
            if (i >= 3) begin
                if (!done) begin
                    $display("test %0d: no done pulse for request %0d", cur_test, i - 3);
                    test_errs++;
                end
                check_value("rslt", b2b_r[i-3], rslt);
            end
            go <= i < N_B2B;
            if (i < N_B2B) req <= b2b_req[i];
        end
        close_test("back-to-back");

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+dv
common/kcpu_pkg.sv
alu/kcpu_div.sv
alu/kcpu_alu.sv
hdl/kcpu_exec.sv
dv/kcpu_exec_tb.sv

/* Bender.yml */
package:
  name: kcpu_exec

sources:
  - common/kcpu_pkg.sv
  - alu/kcpu_div.sv
  - alu/kcpu_alu.sv
  - hdl/kcpu_exec.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/kcpu_exec_tb.sv
